// File: dv/rv_core_tb.sv
`include "rv_consts.svh"

module rv_core_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] DATA_BASE    = 32'h0000_0100;
  localparam logic [31:0] POISON_ADDR  = 32'h0000_07f0;
  localparam int          IMEM_WORDS   = 64;
  localparam int          DMEM_WORDS   = 1024;
  localparam int          RESET_CYCLES = 8;

  logic                   clk;
  logic                   rst_n;
  logic                   imem_ren;
  logic [`RV_XLEN-1:0]    imem_raddr;
  logic [`RV_XLEN-1:0]    imem_rdata;
  logic                   dmem_ren;
  logic [`RV_XLEN-1:0]    dmem_raddr;
  logic [`RV_XLEN-1:0]    dmem_rdata;
  logic                   dmem_we;
  logic [`RV_XLEN-1:0]    dmem_waddr;
  logic [`RV_XLEN-1:0]    dmem_wdata;
  logic [`RV_WSTRB_W-1:0] dmem_wstrb;
  logic                   ebreak;
  logic                   trap;

  // Memory models
  logic [31:0] imem [0:IMEM_WORDS-1];
  logic [31:0] dmem [0:DMEM_WORDS-1];

  // Expected stores in program order
  logic [31:0] exp_addr [0:15];
  logic [31:0] exp_data [0:15];
  int          exp_count;
  int          store_idx = 0;
  logic [31:0] exp_waddr;
  logic [31:0] exp_wdata;
  logic [31:0] load_addr;
  // Selects which sticky flag the running program ends with
  logic        expect_trap;
  logic        rst_n_q = 1'b1;
  logic [31:0] lfsr;
  int          pc_asm;

  rv_core DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .imem_ren   (imem_ren),
    .imem_raddr (imem_raddr),
    .imem_rdata (imem_rdata),
    .dmem_ren   (dmem_ren),
    .dmem_raddr (dmem_raddr),
    .dmem_rdata (dmem_rdata),
    .dmem_we    (dmem_we),
    .dmem_waddr (dmem_waddr),
    .dmem_wdata (dmem_wdata),
    .dmem_wstrb (dmem_wstrb),
    .ebreak     (ebreak),
    .trap       (trap)
  );

  always #10 clk = ~clk;

  // Both SRAMs answer in the same cycle
  assign imem_rdata = imem[imem_raddr[7:2]];
  // Data SRAM returns zero unless a read is requested
  assign dmem_rdata = dmem_ren ? dmem[dmem_raddr[11:2]] : '0;
  assign exp_waddr  = exp_addr[store_idx[3:0]];
  assign exp_wdata  = exp_data[store_idx[3:0]];

  always @(posedge clk) begin
    if (dmem_we) begin
      dmem[dmem_waddr[11:2]] <= dmem_wdata;
    end
  end

  // Store counter and one-edge delayed reset
  always @(posedge clk) begin
    rst_n_q <= rst_n;
    if (!rst_n) begin
      store_idx <= 0;
    end else if (dmem_we) begin
      store_idx <= store_idx + 1;
    end
  end

  // --------------------
  // Checks
  // --------------------
  // Sync reset, so the state is known from the second low edge on
  a_reset_quiet : assert property (@(posedge clk) !rst_n_q |-> !(dmem_we || ebreak || trap))
    else begin
      $display("[ERROR] %0t dmem_we/ebreak/trap expected 0/0/0 actual %b/%b/%b", $time,
               $sampled(dmem_we), $sampled(ebreak), $sampled(trap));
      abort_run();
    end

  a_reset_pc : assert property (@(posedge clk) !rst_n_q |-> imem_raddr == `RV_RESET_PC)
    else begin
      $display("[ERROR] %0t imem_raddr expected %h actual %h", $time, `RV_RESET_PC,
               $sampled(imem_raddr));
      abort_run();
    end

  // Every store must be the next one on the list
  a_store_count : assert property (@(posedge clk) disable iff (!rst_n)
                                   dmem_we |-> store_idx < exp_count)
    else begin
      $display("%0t: store to %h occurred after the last expected store", $time,
               $sampled(dmem_waddr));
      abort_run();
    end

  a_store_addr : assert property (@(posedge clk) disable iff (!rst_n)
                                  dmem_we |-> dmem_waddr == exp_waddr)
    else begin
      $display("[ERROR] %0t dmem_waddr expected %h actual %h", $time, $sampled(exp_waddr),
               $sampled(dmem_waddr));
      abort_run();
    end

  a_store_data : assert property (@(posedge clk) disable iff (!rst_n)
                                  dmem_we |-> dmem_wdata == exp_wdata)
    else begin
      $display("[ERROR] %0t dmem_wdata expected %h actual %h", $time, $sampled(exp_wdata),
               $sampled(dmem_wdata));
      abort_run();
    end

  a_wstrb : assert property (@(posedge clk) disable iff (!rst_n)
                             dmem_we |-> dmem_wstrb == 4'hf)
    else begin
      $display("[ERROR] %0t dmem_wstrb expected f actual %h", $time, $sampled(dmem_wstrb));
      abort_run();
    end

  // Skipped stores all aim here
  a_no_poison : assert property (@(posedge clk) disable iff (!rst_n)
                                 dmem_we |-> dmem_waddr != POISON_ADDR)
    else begin
      $display("%0t: a store that a branch or jump should skip was executed", $time);
      abort_run();
    end

  a_load_addr : assert property (@(posedge clk) disable iff (!rst_n)
                                 dmem_ren |-> dmem_raddr == load_addr)
    else begin
      $display("[ERROR] %0t dmem_raddr expected %h actual %h", $time, $sampled(load_addr),
               $sampled(dmem_raddr));
      abort_run();
    end

  a_no_trap : assert property (@(posedge clk) disable iff (!rst_n) !expect_trap |-> !trap)
    else begin
      $display("[ERROR] %0t trap expected 0 actual %b", $time, $sampled(trap));
      abort_run();
    end

  a_no_ebreak : assert property (@(posedge clk) disable iff (!rst_n) expect_trap |-> !ebreak)
    else begin
      $display("[ERROR] %0t ebreak expected 0 actual %b", $time, $sampled(ebreak));
      abort_run();
    end

  // Halted core keeps its PC and issues nothing
  a_halt_pc : assert property (@(posedge clk) disable iff (!rst_n)
                               (ebreak || trap) |=> $stable(imem_raddr))
    else begin
      $display("%0t: imem_raddr moved to %h after the core halted", $time,
               $sampled(imem_raddr));
      abort_run();
    end

  a_halt_quiet : assert property (@(posedge clk) disable iff (!rst_n)
                                  (ebreak || trap) |-> !(dmem_we || imem_ren))
    else begin
      $display("%0t: store or fetch request seen after the core halted", $time);
      abort_run();
    end

  // --------------------
  // Helpers
  // --------------------
  task automatic abort_run();
    $display("sim failed");
    $fatal(1, "stopping at the first error");
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int nbits, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr = lfsr_step(lfsr);
      val  = {val[30:0], lfsr[0]};
    end
  endtask

  function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  // RV32I instruction formats
  function automatic logic [31:0] enc_r(input logic [2:0] f3, input logic [6:0] f7,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OP_RTYPE};
  endfunction

  function automatic logic [31:0] enc_i(input rv_isa_pkg::opcode_e op, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [4:0] rs2, input logic [4:0] rs1,
                                        input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, rv_isa_pkg::F3_WORD, imm[4:0], rv_isa_pkg::OP_STORE};
  endfunction

  function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                        input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_isa_pkg::OP_BRANCH};
  endfunction

  function automatic logic [31:0] enc_u(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, rv_isa_pkg::OP_LUI};
  endfunction

  function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, rv_isa_pkg::OP_JAL};
  endfunction

  task automatic emit(input logic [31:0] word);
    imem[pc_asm >> 2] = word;
    pc_asm += 4;
  endtask

  task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
    exp_addr[exp_count] = addr;
    exp_data[exp_count] = data;
    exp_count++;
  endtask

  task automatic fill_memories();
    for (int i = 0; i < IMEM_WORDS; i++) begin
      // Opcode bits stay zero, a stray fetch decodes as illegal
      imem[i] = 32'((i * 4) << 7);
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem[i] = 32'h5a5a_0000 ^ 32'(i * 4);
    end
  endtask

  // LUI + ADDI with random immediates
  task automatic load_random(input logic [4:0] rd, output logic [31:0] value);
    logic [31:0] upper;
    logic [31:0] lower;
    draw_bits(20, upper);
    draw_bits(12, lower);
    emit(enc_u(rd, upper[19:0]));
    emit(enc_i(rv_isa_pkg::OP_IMM, rv_isa_pkg::F3_ADD_SUB, rd, rd, lower[11:0]));
    value = {upper[19:0], 12'b0} + sext12(lower[11:0]);
  endtask

  // x3 = x1 op x2, stored at DATA_BASE + ofs
  task automatic alu_case(input logic [2:0] f3, input logic [6:0] f7,
                          input logic [31:0] expected, input logic [11:0] ofs);
    emit(enc_r(f3, f7, 5'd3, 5'd1, 5'd2));
    emit(enc_s(5'd3, 5'd10, ofs));
    expect_store(DATA_BASE + {20'b0, ofs}, expected);
  endtask

  task automatic build_main();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] link;
    logic [31:0] call_pc;
    exp_count = 0;
    pc_asm    = 0;
    load_random(5'd1, a);
    load_random(5'd2, b);
    emit(enc_i(rv_isa_pkg::OP_IMM, rv_isa_pkg::F3_ADD_SUB, 5'd10, 5'd0, DATA_BASE[11:0]));
    alu_case(rv_isa_pkg::F3_ADD_SUB, rv_isa_pkg::F7_ZERO, a + b, 12'd0);
    alu_case(rv_isa_pkg::F3_ADD_SUB, rv_isa_pkg::F7_SUB, a - b, 12'd4);
    alu_case(rv_isa_pkg::F3_AND, rv_isa_pkg::F7_ZERO, a & b, 12'd8);
    alu_case(rv_isa_pkg::F3_OR, rv_isa_pkg::F7_ZERO, a | b, 12'd12);
    alu_case(rv_isa_pkg::F3_XOR, rv_isa_pkg::F7_ZERO, a ^ b, 12'd16);
    alu_case(rv_isa_pkg::F3_SLT, rv_isa_pkg::F7_ZERO, {31'b0, $signed(a) < $signed(b)}, 12'd20);
    // ADDI with a fresh random immediate
    draw_bits(12, c);
    emit(enc_i(rv_isa_pkg::OP_IMM, rv_isa_pkg::F3_ADD_SUB, 5'd3, 5'd1, c[11:0]));
    emit(enc_s(5'd3, 5'd10, 12'd24));
    expect_store(DATA_BASE + 32'd24, a + sext12(c[11:0]));
    // Reload the ADD result and store it plus a constant
    load_addr = DATA_BASE;
    emit(enc_i(rv_isa_pkg::OP_LOAD, rv_isa_pkg::F3_WORD, 5'd4, 5'd10, 12'd0));
    emit(enc_i(rv_isa_pkg::OP_IMM, rv_isa_pkg::F3_ADD_SUB, 5'd4, 5'd4, 12'h055));
    emit(enc_s(5'd4, 5'd10, 12'd28));
    expect_store(DATA_BASE + 32'd28, a + b + 32'h55);
    // ---- Control flow, each taken branch skips one poisoned store
    emit(enc_b(rv_isa_pkg::F3_BEQ, 5'd1, 5'd1, 13'd8));
    emit(enc_s(5'd3, 5'd0, POISON_ADDR[11:0]));
    emit(enc_i(rv_isa_pkg::OP_IMM, rv_isa_pkg::F3_ADD_SUB, 5'd5, 5'd0, 12'hfff));
    // -1 < 0 only when compared signed
    emit(enc_b(rv_isa_pkg::F3_BLT, 5'd5, 5'd0, 13'd8));
    emit(enc_s(5'd3, 5'd0, POISON_ADDR[11:0]));
    // BNE on equal operands falls through
    emit(enc_b(rv_isa_pkg::F3_BNE, 5'd1, 5'd1, 13'd8));
    emit(enc_s(5'd5, 5'd10, 12'd32));
    expect_store(DATA_BASE + 32'd32, 32'hffff_ffff);
    link = 32'(pc_asm + 4);
    emit(enc_j(5'd6, 21'd8));
    emit(enc_s(5'd3, 5'd0, POISON_ADDR[11:0]));
    emit(enc_s(5'd6, 5'd10, 12'd36));
    expect_store(DATA_BASE + 32'd36, link);
    // Call forward over the EBREAK, return with JALR
    call_pc = 32'(pc_asm);
    emit(enc_j(5'd7, 21'd12));
    emit(enc_s(5'd1, 5'd10, 12'd44));
    emit(rv_isa_pkg::EBREAK_WORD);
    emit(enc_s(5'd7, 5'd10, 12'd40));
    emit(enc_i(rv_isa_pkg::OP_JALR, 3'b000, 5'd0, 5'd7, 12'd0));
    expect_store(DATA_BASE + 32'd40, call_pc + 32'd4);
    expect_store(DATA_BASE + 32'd44, a);
  endtask

  // One good store, then an undefined word
  task automatic build_illegal();
    logic [31:0] d;
    exp_count = 0;
    pc_asm    = 0;
    load_addr = 32'hffff_fffc;
    load_random(5'd1, d);
    emit(enc_s(5'd1, 5'd0, 12'h200));
    expect_store(32'h0000_0200, d);
    emit(32'hffff_ffff);
    emit(enc_s(5'd1, 5'd0, 12'h204));
    emit(rv_isa_pkg::EBREAK_WORD);
  endtask

  task automatic release_reset(input int limit);
    int cycles;
    cycles = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    while (!(rst_n && imem_ren) && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (!(rst_n && imem_ren)) begin
      $display("Timeout: fetch did not start after reset release");
      abort_run();
    end
  endtask

  task automatic wait_next_store(input int idx, input int limit);
    int cycles;
    cycles = 0;
    while (store_idx <= idx && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (store_idx <= idx) begin
      $display("Timeout: store %0d of %0d never appeared", idx + 1, exp_count);
      abort_run();
    end
  endtask

  task automatic wait_halt(input int limit);
    int cycles;
    cycles = 0;
    while (!(expect_trap ? trap : ebreak) && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (!(expect_trap ? trap : ebreak)) begin
      $display("Timeout: the core did not halt with the expected flag");
      abort_run();
    end
  endtask

  // --------------------
  // Stimulus
  // --------------------
  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    lfsr        = 32'hbb19;
    expect_trap = 1'b0;
    fill_memories();
    build_main();
    release_reset(10);
    for (int i = 0; i < exp_count; i++) begin
      wait_next_store(i, 40);
    end
    wait_halt(40);
    // Watch the halted core for a while
    repeat (8) @(negedge clk);

    // Second run ends on an illegal word
    @(posedge clk);
    rst_n       <= 1'b0;
    expect_trap <= 1'b1;
    @(negedge clk);
    fill_memories();
    build_illegal();
    release_reset(10);
    for (int i = 0; i < exp_count; i++) begin
      wait_next_store(i, 40);
    end
    wait_halt(40);
    repeat (8) @(negedge clk);

    $display("sim passed");
    $finish;
  end

endmodule

// File: hdl/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// --------------------
// Datapath widths
// --------------------

// Data and address width
`define RV_XLEN 32

// Register index width and register count
`define RV_REG_AW 5
`define RV_NUM_REGS 32

// Instruction word width
`define RV_INSTR_W 32

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// One strobe bit per data byte
`define RV_WSTRB_W 4

`endif

// File: hdl/rv_core.sv
`include "rv_consts.svh"

module rv_core (
  input  logic                   clk,
  input  logic                   rst_n,

  // Instruction memory, read only
  output logic                   imem_ren,
  output logic [`RV_XLEN-1:0]    imem_raddr,
  input  logic [`RV_XLEN-1:0]    imem_rdata,

  // Data memory read
  output logic                   dmem_ren,
  output logic [`RV_XLEN-1:0]    dmem_raddr,
  input  logic [`RV_XLEN-1:0]    dmem_rdata,

  // Data memory write
  output logic                   dmem_we,
  output logic [`RV_XLEN-1:0]    dmem_waddr,
  output logic [`RV_XLEN-1:0]    dmem_wdata,
  output logic [`RV_WSTRB_W-1:0] dmem_wstrb,

  output logic                   ebreak,
  output logic                   trap
);

  // --------------------
  // Inter-module wires
  // --------------------
  rv_core_pkg::fetch_t    fetch;
  rv_core_pkg::dec_t      dec;
  rv_core_pkg::ex_t       ex;
  rv_core_pkg::redirect_t redirect;
  rv_core_pkg::wb_t       wb;
  logic [`RV_REG_AW-1:0]  rs1_addr;
  logic [`RV_REG_AW-1:0]  rs2_addr;
  logic [`RV_XLEN-1:0]    rs1_data;
  logic [`RV_XLEN-1:0]    rs2_data;
  logic                   halt;

  rv_fetch u_fetch (
    .clk        (clk),
    .rst_n      (rst_n),
    .redirect   (redirect),
    .halt       (halt),
    .imem_ren   (imem_ren),
    .imem_raddr (imem_raddr),
    .imem_rdata (imem_rdata),
    .fetch      (fetch)
  );

  rv_decode u_decode (
    .fetch    (fetch),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .dec      (dec)
  );

  // Reads settle in the decode cycle, write lands on the edge
  rv_regfile u_regfile (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb       (wb)
  );

  rv_execute u_execute (
    .dec      (dec),
    .ex       (ex),
    .redirect (redirect)
  );

  rv_retire u_retire (
    .clk        (clk),
    .rst_n      (rst_n),
    .ex         (ex),
    .dmem_ren   (dmem_ren),
    .dmem_raddr (dmem_raddr),
    .dmem_rdata (dmem_rdata),
    .dmem_we    (dmem_we),
    .dmem_waddr (dmem_waddr),
    .dmem_wdata (dmem_wdata),
    .dmem_wstrb (dmem_wstrb),
    .wb         (wb),
    .halt       (halt),
    .ebreak     (ebreak),
    .trap       (trap)
  );

endmodule

// File: hdl/rv_core_pkg.sv
`include "rv_consts.svh"

package rv_core_pkg;

  // ALU function
  typedef enum logic [2:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLT,
    PASS_B
  } alu_op_e;

  // Source of the register write-back value
  typedef enum logic [1:0] {
    ALU,
    MEM,
    PC4
  } wb_src_e;

  // Conditional branch flavour
  typedef enum logic [1:0] {
    NONE,
    EQ,
    NE,
    LT
  } br_kind_e;

  // --------------------
  // Fetch to decode
  // --------------------
  typedef struct packed {
    logic [`RV_XLEN-1:0]    pc;
    logic [`RV_INSTR_W-1:0] instr;
    logic [`RV_XLEN-1:0]    pc_plus4;
  } fetch_t;

  // Control word produced by decode
  typedef struct packed {
    alu_op_e  alu_op;
    wb_src_e  wb_src;
    br_kind_e br_kind;
    logic     is_jal;
    logic     is_jalr;
    logic     reg_write;
    logic     mem_read;
    logic     mem_write;
    logic     ebreak;
    logic     illegal;
    logic     alu_b_imm;
    logic     a_is_zero;
  } ctrl_t;

  // --------------------
  // Decode to execute
  // --------------------
  typedef struct packed {
    ctrl_t                 ctrl;
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_XLEN-1:0]   rs1_data;
    logic [`RV_XLEN-1:0]   rs2_data;
    logic [`RV_XLEN-1:0]   imm;
    logic [`RV_XLEN-1:0]   pc;
    logic [`RV_XLEN-1:0]   pc_plus4;
  } dec_t;

  // Execute to retire
  typedef struct packed {
    ctrl_t                 ctrl;
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_XLEN-1:0]   alu_result;
    logic [`RV_XLEN-1:0]   store_data;
    logic [`RV_XLEN-1:0]   pc_plus4;
  } ex_t;

  // Execute back to fetch
  typedef struct packed {
    logic                taken;
    logic [`RV_XLEN-1:0] target;
  } redirect_t;

  // Retire to register file
  typedef struct packed {
    logic                  we;
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_XLEN-1:0]   data;
  } wb_t;

endpackage

// File: hdl/rv_decode.sv
`include "rv_consts.svh"

module rv_decode (
  input  rv_core_pkg::fetch_t      fetch,
  output logic [`RV_REG_AW-1:0]    rs1_addr,
  output logic [`RV_REG_AW-1:0]    rs2_addr,
  input  logic [`RV_XLEN-1:0]      rs1_data,
  input  logic [`RV_XLEN-1:0]      rs2_data,
  output rv_core_pkg::dec_t        dec
);

  logic [`RV_INSTR_W-1:0] instr;
  rv_isa_pkg::opcode_e    opcode;
  logic [2:0]             funct3;
  logic [6:0]             funct7;
  rv_core_pkg::ctrl_t     ctrl;
  logic [`RV_XLEN-1:0]    imm;

  // --------------------
  // Field extraction
  // --------------------
  assign instr  = fetch.instr;
  assign opcode = rv_isa_pkg::opcode_e'(instr[6:0]);
  assign funct3 = instr[rv_isa_pkg::F3_LSB +: 3];
  assign funct7 = instr[rv_isa_pkg::F7_LSB +: 7];

  assign rs1_addr = instr[rv_isa_pkg::RS1_LSB +: `RV_REG_AW];
  assign rs2_addr = instr[rv_isa_pkg::RS2_LSB +: `RV_REG_AW];

  // Control decode
  always_comb begin
    ctrl = '0;
    // ALU result is ignored unless an opcode below picks a real op
    ctrl.alu_op  = rv_core_pkg::PASS_B;
    ctrl.wb_src  = rv_core_pkg::ALU;
    ctrl.br_kind = rv_core_pkg::NONE;
    case (opcode)
      rv_isa_pkg::OP_LUI: begin
        // rd = 0 + U-immediate
        ctrl.alu_op    = rv_core_pkg::ADD;
        ctrl.a_is_zero = 1'b1;
        ctrl.alu_b_imm = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      rv_isa_pkg::OP_IMM: begin
        ctrl.alu_op    = rv_core_pkg::ADD;
        ctrl.alu_b_imm = 1'b1;
        ctrl.reg_write = 1'b1;
        // ADDI only
        ctrl.illegal   = (funct3 != rv_isa_pkg::F3_ADD_SUB);
      end
      rv_isa_pkg::OP_RTYPE: begin
        ctrl.reg_write = 1'b1;
        if (funct7 == rv_isa_pkg::F7_SUB && funct3 == rv_isa_pkg::F3_ADD_SUB) begin
          ctrl.alu_op = rv_core_pkg::SUB;
        end else if (funct7 != rv_isa_pkg::F7_ZERO) begin
          ctrl.illegal = 1'b1;
        end else begin
          case (funct3)
            rv_isa_pkg::F3_ADD_SUB: ctrl.alu_op = rv_core_pkg::ADD;
            rv_isa_pkg::F3_SLT:     ctrl.alu_op = rv_core_pkg::SLT;
            rv_isa_pkg::F3_XOR:     ctrl.alu_op = rv_core_pkg::XOR;
            rv_isa_pkg::F3_OR:      ctrl.alu_op = rv_core_pkg::OR;
            rv_isa_pkg::F3_AND:     ctrl.alu_op = rv_core_pkg::AND;
            default:                ctrl.illegal = 1'b1;
          endcase
        end
      end
      rv_isa_pkg::OP_BRANCH: begin
        case (funct3)
          rv_isa_pkg::F3_BEQ: ctrl.br_kind = rv_core_pkg::EQ;
          rv_isa_pkg::F3_BNE: ctrl.br_kind = rv_core_pkg::NE;
          rv_isa_pkg::F3_BLT: ctrl.br_kind = rv_core_pkg::LT;
          default:            ctrl.illegal = 1'b1;
        endcase
      end
      rv_isa_pkg::OP_JAL: begin
        ctrl.is_jal    = 1'b1;
        ctrl.wb_src    = rv_core_pkg::PC4;
        ctrl.reg_write = 1'b1;
      end
      rv_isa_pkg::OP_JALR: begin
        ctrl.is_jalr   = 1'b1;
        ctrl.wb_src    = rv_core_pkg::PC4;
        ctrl.reg_write = 1'b1;
        ctrl.illegal   = (funct3 != 3'b000);
      end
      rv_isa_pkg::OP_LOAD: begin
        // Address = rs1 + I-immediate
        ctrl.alu_op    = rv_core_pkg::ADD;
        ctrl.alu_b_imm = 1'b1;
        ctrl.mem_read  = 1'b1;
        ctrl.wb_src    = rv_core_pkg::MEM;
        ctrl.reg_write = 1'b1;
        ctrl.illegal   = (funct3 != rv_isa_pkg::F3_WORD);
      end
      rv_isa_pkg::OP_STORE: begin
        ctrl.alu_op    = rv_core_pkg::ADD;
        ctrl.alu_b_imm = 1'b1;
        ctrl.mem_write = 1'b1;
        ctrl.illegal   = (funct3 != rv_isa_pkg::F3_WORD);
      end
      rv_isa_pkg::OP_SYSTEM: begin
        ctrl.ebreak  = (instr == rv_isa_pkg::EBREAK_WORD);
        ctrl.illegal = (instr != rv_isa_pkg::EBREAK_WORD);
      end
      default: ctrl.illegal = 1'b1;
    endcase
    // Halting words change no architectural state
    if (ctrl.illegal || ctrl.ebreak) begin
      ctrl.reg_write = 1'b0;
      ctrl.mem_read  = 1'b0;
      ctrl.mem_write = 1'b0;
    end
  end

  // --------------------
  // Immediate generation
  // --------------------
  always_comb begin
    case (opcode)
      rv_isa_pkg::OP_LUI: imm = {instr[31:12], 12'b0};
      rv_isa_pkg::OP_STORE: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      rv_isa_pkg::OP_BRANCH:
        imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      rv_isa_pkg::OP_JAL:
        imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      // I-type for ADDI, JALR and LW
      default: imm = {{20{instr[31]}}, instr[31:20]};
    endcase
  end

  assign dec.ctrl     = ctrl;
  assign dec.rd       = instr[rv_isa_pkg::RD_LSB +: `RV_REG_AW];
  assign dec.rs1_data = rs1_data;
  assign dec.rs2_data = rs2_data;
  assign dec.imm      = imm;
  assign dec.pc       = fetch.pc;
  assign dec.pc_plus4 = fetch.pc_plus4;

endmodule

// File: hdl/rv_execute.sv
`include "rv_consts.svh"

module rv_execute (
  input  rv_core_pkg::dec_t      dec,
  output rv_core_pkg::ex_t       ex,
  output rv_core_pkg::redirect_t redirect
);

  logic [`RV_XLEN-1:0] alu_a;
  logic [`RV_XLEN-1:0] alu_b;
  logic [`RV_XLEN-1:0] alu_result;
  logic                rs_eq;
  logic                rs_lt;
  logic                br_taken;
  logic [`RV_XLEN-1:0] jalr_sum;

  // --------------------
  // ALU operands
  // --------------------
  // Zero in place of rs1 for LUI
  assign alu_a = dec.ctrl.a_is_zero ? '0 : dec.rs1_data;
  assign alu_b = dec.ctrl.alu_b_imm ? dec.imm : dec.rs2_data;

  always_comb begin
    case (dec.ctrl.alu_op)
      rv_core_pkg::ADD: alu_result = alu_a + alu_b;
      rv_core_pkg::SUB: alu_result = alu_a - alu_b;
      rv_core_pkg::AND: alu_result = alu_a & alu_b;
      rv_core_pkg::OR:  alu_result = alu_a | alu_b;
      rv_core_pkg::XOR: alu_result = alu_a ^ alu_b;
      rv_core_pkg::SLT: begin
        alu_result = {{(`RV_XLEN - 1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
      end
      default: alu_result = alu_b;
    endcase
  end

  // --------------------
  // Branch compare
  // --------------------
  assign rs_eq = (dec.rs1_data == dec.rs2_data);
  // BLT is the only ordered compare, always signed
  assign rs_lt = ($signed(dec.rs1_data) < $signed(dec.rs2_data));

  always_comb begin
    case (dec.ctrl.br_kind)
      rv_core_pkg::EQ: br_taken = rs_eq;
      rv_core_pkg::NE: br_taken = !rs_eq;
      rv_core_pkg::LT: br_taken = rs_lt;
      default:         br_taken = 1'b0;
    endcase
  end

  // Redirect target
  assign jalr_sum = dec.rs1_data + dec.imm;

  assign redirect.taken  = br_taken || dec.ctrl.is_jal || dec.ctrl.is_jalr;
  // JALR drops bit 0, branches and JAL are PC relative
  assign redirect.target = dec.ctrl.is_jalr ? {jalr_sum[`RV_XLEN-1:1], 1'b0}
                                            : dec.pc + dec.imm;

  assign ex.ctrl       = dec.ctrl;
  assign ex.rd         = dec.rd;
  assign ex.alu_result = alu_result;
  assign ex.store_data = dec.rs2_data;
  assign ex.pc_plus4   = dec.pc_plus4;

endmodule

// File: hdl/rv_fetch.sv
`include "rv_consts.svh"

module rv_fetch (
  input  logic                   clk,
  input  logic                   rst_n,
  input  rv_core_pkg::redirect_t redirect,
  input  logic                   halt,
  output logic                   imem_ren,
  output logic [`RV_XLEN-1:0]    imem_raddr,
  input  logic [`RV_XLEN-1:0]    imem_rdata,
  output rv_core_pkg::fetch_t    fetch
);

  logic [`RV_XLEN-1:0] pc;
  logic [`RV_XLEN-1:0] pc_plus4;
  logic [`RV_XLEN-1:0] pc_next;

  assign pc_plus4 = pc + `RV_XLEN'd4;

  // Halt freezes the PC, then taken redirect, else sequential
  always_comb begin
    if (halt) begin
      pc_next = pc;
    end else if (redirect.taken) begin
      pc_next = redirect.target;
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= `RV_RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

  // SRAM answers in the same cycle
  assign imem_ren   = !halt;
  assign imem_raddr = pc;

  assign fetch.pc       = pc;
  assign fetch.instr    = imem_rdata;
  assign fetch.pc_plus4 = pc_plus4;

  // Jump targets from execute must keep word alignment
  a_pc_aligned : assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00);

endmodule

// File: hdl/rv_isa_pkg.sv
package rv_isa_pkg;

  // --------------------
  // Major opcodes
  // --------------------
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_IMM    = 7'b0010011,
    OP_RTYPE  = 7'b0110011,
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  // ALU funct3
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // Branch funct3
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;
  localparam logic [2:0] F3_BLT = 3'b100;

  // Load/store width, only full words here
  localparam logic [2:0] F3_WORD = 3'b010;

  // funct7 values of R-type
  localparam logic [6:0] F7_ZERO = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

  // Only SYSTEM word that is legal
  localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

  // --------------------
  // Field positions
  // --------------------
  localparam int RD_LSB  = 7;
  localparam int F3_LSB  = 12;
  localparam int RS1_LSB = 15;
  localparam int RS2_LSB = 20;
  localparam int F7_LSB  = 25;

endpackage

// File: hdl/rv_regfile.sv
`include "rv_consts.svh"

module rv_regfile (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`RV_REG_AW-1:0]  rs1_addr,
  input  logic [`RV_REG_AW-1:0]  rs2_addr,
  output logic [`RV_XLEN-1:0]    rs1_data,
  output logic [`RV_XLEN-1:0]    rs2_data,
  input  rv_core_pkg::wb_t       wb
);

  // x1..x31, x0 is not stored
  logic [`RV_XLEN-1:0] regs [1:`RV_NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 1; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.we && wb.rd != '0) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // --------------------
  // Combinational reads
  // --------------------
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

  // Retire turns writes to x0 into discards with the enable low
  a_no_x0_write : assert property (
    @(posedge clk) disable iff (!rst_n) wb.we |-> (wb.rd != '0)
  );

endmodule

// File: hdl/rv_retire.sv
`include "rv_consts.svh"

module rv_retire (
  input  logic                    clk,
  input  logic                    rst_n,
  input  rv_core_pkg::ex_t        ex,
  output logic                    dmem_ren,
  output logic [`RV_XLEN-1:0]     dmem_raddr,
  input  logic [`RV_XLEN-1:0]     dmem_rdata,
  output logic                    dmem_we,
  output logic [`RV_XLEN-1:0]     dmem_waddr,
  output logic [`RV_XLEN-1:0]     dmem_wdata,
  output logic [`RV_WSTRB_W-1:0]  dmem_wstrb,
  output rv_core_pkg::wb_t        wb,
  output logic                    halt,
  output logic                    ebreak,
  output logic                    trap
);

  logic stop;

  // --------------------
  // Data memory
  // --------------------
  // Halted core issues nothing
  assign dmem_ren   = ex.ctrl.mem_read && !halt;
  assign dmem_raddr = ex.alu_result;
  assign dmem_we    = ex.ctrl.mem_write && !halt;
  assign dmem_waddr = ex.alu_result;
  assign dmem_wdata = ex.store_data;
  // Word stores only
  assign dmem_wstrb = {`RV_WSTRB_W{dmem_we}};

  // Write-back, x0 targets are discarded here
  assign wb.we = ex.ctrl.reg_write && !halt && (ex.rd != '0);
  assign wb.rd = ex.rd;

  always_comb begin
    case (ex.ctrl.wb_src)
      rv_core_pkg::MEM: wb.data = dmem_rdata;
      rv_core_pkg::PC4: wb.data = ex.pc_plus4;
      default:          wb.data = ex.alu_result;
    endcase
  end

  // --------------------
  // Halt and sticky status
  // --------------------
  assign stop = ex.ctrl.ebreak || ex.ctrl.illegal;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      halt   <= 1'b0;
      ebreak <= 1'b0;
      trap   <= 1'b0;
    end else begin
      halt   <= halt || stop;
      // First halting word decides which flag rises
      ebreak <= ebreak || (ex.ctrl.ebreak && !halt);
      trap   <= trap || (ex.ctrl.illegal && !halt);
    end
  end

  // Decode never asks for a load and a store at once
  a_rd_wr_excl : assert property (
    @(posedge clk) disable iff (!rst_n) !(dmem_we && dmem_ren)
  );

  // Halt is sticky and keeps memory quiet until reset
  a_halt_quiet : assert property (
    @(posedge clk) disable iff (!rst_n) halt |=> (halt && !dmem_we && !dmem_ren)
  );

endmodule

// File: vlog.f
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/rv_core_pkg.sv
hdl/rv_fetch.sv
hdl/rv_decode.sv
hdl/rv_regfile.sv
hdl/rv_execute.sv
hdl/rv_retire.sv
hdl/rv_core.sv
dv/rv_core_tb.sv
